//--- red_pitaya_ps.f
+incdir+include
src/rp_axi_pkg.sv
src/rp_sys_pkg.sv
src/sys_bus_if.sv
src/axi4_slave.sv
src/sys_bus_interconnect.sv
src/rp_housekeeping.sv
src/rp_irq_ctrl.sv
src/red_pitaya_ps.sv
tb/red_pitaya_ps_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PS bridge testbench with Verilator, run it into sim.log
# and fail when the log reports a failed check

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module red_pitaya_ps_tb -f red_pitaya_ps.f \
  && ./obj_dir/Vred_pitaya_ps_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

//--- tb/red_pitaya_ps_tb.sv
// Testbench for the PS bridge
// Applies a table of AXI transfers and pin changes, checks responses,
// read data and board pins against a shadow register model
`timescale 1ns/1ps
`default_nettype none
`include "rp_bus_defines.svh"

module red_pitaya_ps_tb
  import rp_axi_pkg::*;
();

localparam logic [31:0] HK_BASE   = 32'h4000_0000;  // Slot 0
localparam logic [31:0] IRQ_BASE  = 32'h4010_0000;  // Slot 1
localparam logic [31:0] NONE_BASE = 32'h4030_0000;  // Unmapped slot
localparam logic [31:0] PIN_GPIO  = 32'd0;          // Pin entry targets
localparam logic [31:0] PIN_IRQ   = 32'd1;
localparam int          HS_LIMIT   = 16;
localparam int          RESP_LIMIT = 16;
localparam int          PIN_WAIT   = 6;  // Covers sync, edge detect and irq_o flop

typedef enum logic [1:0] {OP_WR, OP_RD, OP_PINS} op_e;

typedef struct packed {
  op_e         op;
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;
  logic [31:0] exp;   // Read data
  axi_resp_e   resp;
} entry_t;

logic               clk_i;
logic               rst_n_i;
logic [`SYS_AW-1:0] awaddr_i;
logic               awvalid_i;
logic               awready_o;
logic [`SYS_DW-1:0] wdata_i;
logic [`SYS_SW-1:0] wstrb_i;
logic               wvalid_i;
logic               wready_o;
logic               bvalid_o;
logic [1:0]         bresp_o;
logic               bready_i;
logic [`SYS_AW-1:0] araddr_i;
logic               arvalid_i;
logic               arready_o;
logic               rvalid_o;
logic [`SYS_DW-1:0] rdata_o;
logic [1:0]         rresp_o;
logic               rready_i;
logic [`LED_W-1:0]  led_o;
logic [`GPIO_W-1:0] gpio_i;
logic [`GPIO_W-1:0] gpio_o;
logic [`GPIO_W-1:0] gpio_t_o;
logic [`IRQ_W-1:0]  irq_i;
logic               irq_o;

// Shadow registers
logic [`LED_W-1:0]  m_led;
logic [`GPIO_W-1:0] m_gpio_o;
logic [`GPIO_W-1:0] m_gpio_t;
logic [`IRQ_W-1:0]  m_pend;
logic [`IRQ_W-1:0]  m_mask;
logic [`IRQ_W-1:0]  m_lines;  // Last level driven on irq_i

entry_t      tbl [$];
logic [31:0] lfsr_q;
int          err_cnt;
int          cycles;
int          cycle_limit;

red_pitaya_ps dut_i (.*);

always #5 clk_i = ~clk_i;

//////////////////////////////
// Helpers
//////////////////////////////

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] next_lfsr(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

task automatic draw_bits(input int n, output int val);
  val = 0;
  for (int b = 0; b < n; b++) begin
    lfsr_q = next_lfsr(lfsr_q);
    val    = (val << 1) | int'(lfsr_q[0]);  // One step per bit
  end
endtask

function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
  return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
endfunction

task automatic add_entry(input op_e op, input logic [31:0] addr, data,
                         input logic [3:0] strb, input logic [31:0] exp,
                         input axi_resp_e resp);
  entry_t e;
  e.op   = op;
  e.addr = addr;
  e.data = data;
  e.strb = strb;
  e.exp  = exp;
  e.resp = resp;
  tbl.push_back(e);
endtask

// Accepted writes only, error writes change nothing
task automatic model_write(input logic [31:0] addr, data, input logic [3:0] strb);
  logic [31:0] m;
  logic [31:0] v;
  logic [19:0] ofs;
  m   = strobe_mask(strb);
  ofs = addr[`SLV_SEL_LSB-1:0];
  if (addr[`SLV_SEL_MSB:`SLV_SEL_LSB] == 4'd0) begin
    case (ofs)
      20'h04: begin
        v     = (32'(m_led) & ~m) | (data & m);
        m_led = v[`LED_W-1:0];
      end
      20'h08: begin
        v        = (32'(m_gpio_o) & ~m) | (data & m);
        m_gpio_o = v[`GPIO_W-1:0];
      end
      20'h0C: begin
        v        = (32'(m_gpio_t) & ~m) | (data & m);
        m_gpio_t = v[`GPIO_W-1:0];
      end
      default: ;
    endcase
  end else if (addr[`SLV_SEL_MSB:`SLV_SEL_LSB] == 4'd1) begin
    v = data & m;
    if (ofs == 20'h00) m_pend = m_pend & ~v[`IRQ_W-1:0];  // Write one to clear
    if (ofs == 20'h04) begin
      v      = (32'(m_mask) & ~m) | (data & m);
      m_mask = v[`IRQ_W-1:0];
    end
  end
endtask

task automatic model_pins(input logic [31:0] target, data);
  if (target == PIN_GPIO) begin
    gpio_i = data[`GPIO_W-1:0];
  end else begin
    m_pend  = m_pend | (data[`IRQ_W-1:0] & ~m_lines);  // Rising edges only
    m_lines = data[`IRQ_W-1:0];
    irq_i   = data[`IRQ_W-1:0];
  end
endtask

task automatic check_pins(input string label);
  logic exp_irq;
  exp_irq = |(m_pend & m_mask);
  assert (led_o == m_led) else begin
    $display("[FAIL] %s led_o: got 0x%0h expected 0x%0h", label, led_o, m_led);
    err_cnt++;
  end
  assert (gpio_o == m_gpio_o) else begin
    $display("[FAIL] %s gpio_o: got 0x%0h expected 0x%0h", label, gpio_o, m_gpio_o);
    err_cnt++;
  end
  assert (gpio_t_o == m_gpio_t) else begin
    $display("[FAIL] %s gpio_t_o: got 0x%0h expected 0x%0h", label, gpio_t_o, m_gpio_t);
    err_cnt++;
  end
  assert (irq_o == exp_irq) else begin
    $display("[FAIL] %s irq_o: got 0x%0h expected 0x%0h", label, irq_o, exp_irq);
    err_cnt++;
  end
endtask

// Response must not move while the host holds ready low
task automatic check_held(input logic is_wr, input logic [1:0] resp0,
                          input logic [31:0] rd0, input int idx);
  logic       vld;
  logic [1:0] resp;
  vld  = is_wr ? bvalid_o : rvalid_o;
  resp = is_wr ? bresp_o : rresp_o;
  assert (vld) else begin
    $display("Entry %0d: response valid dropped before it was taken", idx);
    err_cnt++;
  end
  assert (resp == resp0) else begin
    $display("[FAIL] entry %0d %s: got 0x%0h expected 0x%0h", idx,
             is_wr ? "bresp_o" : "rresp_o", resp, resp0);
    err_cnt++;
  end
  assert (is_wr || rdata_o == rd0) else begin
    $display("[FAIL] entry %0d rdata_o: got 0x%0h expected 0x%0h", idx, rdata_o, rd0);
    err_cnt++;
  end
  assert (!awready_o && !arready_o) else begin
    $display("Entry %0d: new address accepted while a response was pending", idx);
    err_cnt++;
  end
endtask

// One AXI transfer, entered and left 1 ns after a rising edge
task automatic axi_transfer(input int idx, input entry_t e, output logic [1:0] resp,
                            output logic [31:0] rd);
  logic is_wr;
  logic hs;
  logic vld;
  int   waited;
  int   lat;
  int   hold;
  is_wr  = (e.op == OP_WR);
  resp   = 2'b11;  // Not a code the bridge returns
  rd     = '0;
  waited = 0;
  lat    = 0;
  draw_bits(2, hold);  // 0 to 3 cycles of back-pressure
  if (is_wr) begin
    awaddr_i  = e.addr;
    wdata_i   = e.data;
    wstrb_i   = e.strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
  end else begin
    araddr_i  = e.addr;
    arvalid_i = 1'b1;
  end
  do begin
    @(negedge clk_i);
    hs = is_wr ? (awready_o && wready_o) : arready_o;
    @(posedge clk_i);
    #1;
    waited++;
  end while (!hs && waited < HS_LIMIT);
  awvalid_i = 1'b0;
  wvalid_i  = 1'b0;
  arvalid_i = 1'b0;
  if (!hs) begin
    $display("Entry %0d: address handshake never completed", idx);
    err_cnt++;
    return;
  end
  bready_i = is_wr && hold == 0;  // Ready already up when no hold
  rready_i = !is_wr && hold == 0;
  do begin
    @(negedge clk_i);
    lat++;
    vld = is_wr ? bvalid_o : rvalid_o;
  end while (!vld && lat < RESP_LIMIT);
  if (!vld) begin
    $display("Entry %0d: no response arrived after the address handshake", idx);
    err_cnt++;
    @(posedge clk_i);
    #1;
    return;
  end
  assert (lat == 3) else begin
    $display("[FAIL] entry %0d %s latency: got 0x%0h expected 0x3", idx,
             is_wr ? "bvalid_o" : "rvalid_o", lat);
    err_cnt++;
  end
  resp = is_wr ? bresp_o : rresp_o;
  rd   = is_wr ? '0 : rdata_o;
  if (hold > 0) begin
    check_held(is_wr, resp, rd, idx);
    for (int i = 1; i < hold; i++) begin
      @(negedge clk_i);
      check_held(is_wr, resp, rd, idx);
    end
    @(posedge clk_i);
    #1;
    bready_i = is_wr;
    rready_i = !is_wr;
    @(negedge clk_i);
    check_held(is_wr, resp, rd, idx);
  end
  @(posedge clk_i);  // Response taken here
  #1;
  bready_i = 1'b0;
  rready_i = 1'b0;
  @(negedge clk_i);
  assert (!bvalid_o && !rvalid_o) else begin
    $display("Entry %0d: response still valid after the host took it", idx);
    err_cnt++;
  end
  @(posedge clk_i);
  #1;
endtask

//////////////////////////////
// Stimulus table
//////////////////////////////

task automatic load_table();
  add_entry(OP_RD,   HK_BASE + 'h00,  '0,           4'hF, `HK_ID,       OKAY);
  add_entry(OP_WR,   HK_BASE + 'h04,  32'h0000_00A5, 4'hF, '0,          OKAY);
  add_entry(OP_RD,   HK_BASE + 'h04,  '0,           4'hF, 32'h0000_00A5, OKAY);
  add_entry(OP_WR,   HK_BASE + 'h08,  32'h1234_5678, 4'h1, '0,          OKAY);
  add_entry(OP_WR,   HK_BASE + 'h08,  32'hAABB_CCDD, 4'h2, '0,          OKAY);
  add_entry(OP_RD,   HK_BASE + 'h08,  '0,           4'hF, 32'h0000_CC78, OKAY);
  add_entry(OP_WR,   HK_BASE + 'h0C,  32'h0000_00F0, 4'h1, '0,          OKAY);
  add_entry(OP_RD,   HK_BASE + 'h0C,  '0,           4'hF, 32'h0000_FFF0, OKAY);
  add_entry(OP_WR,   HK_BASE + 'h04,  32'h0000_3C00, 4'h2, '0,          OKAY);
  add_entry(OP_RD,   HK_BASE + 'h04,  '0,           4'hF, 32'h0000_00A5, OKAY);
  add_entry(OP_PINS, PIN_GPIO,        32'h0000_BEEF, 4'h0, '0,          OKAY);
  add_entry(OP_RD,   HK_BASE + 'h10,  '0,           4'hF, 32'h0000_BEEF, OKAY);
  add_entry(OP_WR,   HK_BASE + 'h00,  32'hFFFF_FFFF, 4'hF, '0,          SLVERR);
  add_entry(OP_RD,   HK_BASE + 'h00,  '0,           4'hF, `HK_ID,       OKAY);
  add_entry(OP_WR,   HK_BASE + 'h10,  32'h0000_1234, 4'hF, '0,          SLVERR);
  add_entry(OP_RD,   HK_BASE + 'h14,  '0,           4'hF, '0,          SLVERR);
  add_entry(OP_WR,   HK_BASE + 'h20,  32'hFFFF_FFFF, 4'hF, '0,          SLVERR);
  add_entry(OP_RD,   IRQ_BASE + 'h04, '0,           4'hF, '0,          OKAY);
  add_entry(OP_WR,   IRQ_BASE + 'h04, 32'h0000_0005, 4'hF, '0,          OKAY);
  add_entry(OP_PINS, PIN_IRQ,         32'h0000_0003, 4'h0, '0,          OKAY);
  add_entry(OP_RD,   IRQ_BASE + 'h08, '0,           4'hF, 32'h0000_0003, OKAY);
  add_entry(OP_RD,   IRQ_BASE + 'h00, '0,           4'hF, 32'h0000_0003, OKAY);
  add_entry(OP_WR,   IRQ_BASE + 'h00, 32'h0000_0001, 4'hF, '0,          OKAY);
  add_entry(OP_RD,   IRQ_BASE + 'h00, '0,           4'hF, 32'h0000_0002, OKAY);
  add_entry(OP_WR,   IRQ_BASE + 'h08, 32'h0000_FFFF, 4'hF, '0,          SLVERR);
  add_entry(OP_WR,   IRQ_BASE + 'h0C, 32'h0000_FFFF, 4'hF, '0,          SLVERR);
  add_entry(OP_WR,   NONE_BASE + 'h04, 32'hFFFF_FFFF, 4'hF, '0,         SLVERR);
  add_entry(OP_RD,   NONE_BASE + 'h00, '0,          4'hF, '0,          SLVERR);
  add_entry(OP_PINS, PIN_IRQ,         32'h0000_0000, 4'h0, '0,          OKAY);
  add_entry(OP_RD,   IRQ_BASE + 'h08, '0,           4'hF, '0,          OKAY);
  add_entry(OP_WR,   IRQ_BASE + 'h04, 32'h0000_0002, 4'h1, '0,          OKAY);
  add_entry(OP_WR,   IRQ_BASE + 'h00, 32'h0000_0002, 4'hF, '0,          OKAY);
  add_entry(OP_RD,   IRQ_BASE + 'h00, '0,           4'hF, '0,          OKAY);
  add_entry(OP_RD,   HK_BASE + 'h04,  '0,           4'hF, 32'h0000_00A5, OKAY);
  add_entry(OP_RD,   HK_BASE + 'h08,  '0,           4'hF, 32'h0000_CC78, OKAY);
  add_entry(OP_RD,   HK_BASE + 'h0C,  '0,           4'hF, 32'h0000_FFF0, OKAY);
endtask

//////////////////////////////
// Main sequence
//////////////////////////////

initial begin
  entry_t      e;
  logic [1:0]  resp;
  logic [31:0] rd;
  clk_i     = 1'b0;
  rst_n_i   = 1'b0;
  awaddr_i  = '0;
  awvalid_i = 1'b0;
  wdata_i   = '0;
  wstrb_i   = '0;
  wvalid_i  = 1'b0;
  bready_i  = 1'b0;
  araddr_i  = '0;
  arvalid_i = 1'b0;
  rready_i  = 1'b0;
  gpio_i    = '0;
  irq_i     = '0;
  m_led     = '0;
  m_gpio_o  = '0;
  m_gpio_t  = '1;  // Tristated after reset
  m_pend    = '0;
  m_mask    = '0;
  m_lines   = '0;
  lfsr_q    = 32'h3a43_7732;
  err_cnt   = 0;
  load_table();
  cycle_limit = tbl.size() * 20 + 50;
  repeat (10) @(posedge clk_i);
  #1;
  rst_n_i = 1'b1;
  check_pins("reset");
  for (int i = 0; i < tbl.size(); i++) begin
    e = tbl[i];
    if (e.op == OP_PINS) begin
      model_pins(e.addr, e.data);
      repeat (PIN_WAIT) @(posedge clk_i);
      #1;
    end else begin
      axi_transfer(i, e, resp, rd);
      assert (resp == e.resp) else begin
        $display("[FAIL] entry %0d %s: got 0x%0h expected 0x%0h", i,
                 e.op == OP_WR ? "bresp_o" : "rresp_o", resp, e.resp);
        err_cnt++;
      end
      assert (e.op == OP_WR || rd == e.exp) else begin
        $display("[FAIL] entry %0d rdata_o: got 0x%0h expected 0x%0h", i, rd, e.exp);
        err_cnt++;
      end
      if (e.op == OP_WR && e.resp == OKAY) model_write(e.addr, e.data, e.strb);
    end
    check_pins($sformatf("entry %0d", i));
  end
  $display("Entries: %0d, errors: %0d", tbl.size(), err_cnt);
  if (err_cnt == 0) begin
    $display("Verification passed");
  end else begin
    $display("Verification failed");
  end
  $finish;
end

// Run length guard
initial cycles = 0;

always @(posedge clk_i) begin
  cycles <= cycles + 1;
  if (cycle_limit > 0 && cycles >= cycle_limit) begin
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Entries: %0d, errors: %0d", tbl.size(), err_cnt + 1);
    $display("Verification failed");
    $finish;
  end
end

endmodule

`default_nettype wire

//--- src/red_pitaya_ps.sv
// PS bridge top level
// AXI slave to system bus, interconnect, housekeeping and
// interrupt controller
`timescale 1ns/1ps
`default_nettype none
`include "rp_bus_defines.svh"

module red_pitaya_ps (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // AXI write
  input  logic [`SYS_AW-1:0] awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  logic [`SYS_DW-1:0] wdata_i,
  input  logic [`SYS_SW-1:0] wstrb_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  output logic               bvalid_o,
  output logic [1:0]         bresp_o,
  input  logic               bready_i,
  // AXI read
  input  logic [`SYS_AW-1:0] araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  output logic               rvalid_o,
  output logic [`SYS_DW-1:0] rdata_o,
  output logic [1:0]         rresp_o,
  input  logic               rready_i,
  // Board pins
  output logic [`LED_W-1:0]  led_o,
  input  logic [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o,
  output logic [`GPIO_W-1:0] gpio_t_o,
  input  logic [`IRQ_W-1:0]  irq_i,
  output logic               irq_o
);

sys_bus_if ps_bus  ();  // Slave to interconnect
sys_bus_if hk_bus  ();
sys_bus_if irq_bus ();

axi4_slave axi_slave_i (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .awaddr_i  (awaddr_i),
  .awvalid_i (awvalid_i),
  .awready_o (awready_o),
  .wdata_i   (wdata_i),
  .wstrb_i   (wstrb_i),
  .wvalid_i  (wvalid_i),
  .wready_o  (wready_o),
  .bvalid_o  (bvalid_o),
  .bresp_o   (bresp_o),
  .bready_i  (bready_i),
  .araddr_i  (araddr_i),
  .arvalid_i (arvalid_i),
  .arready_o (arready_o),
  .rvalid_o  (rvalid_o),
  .rdata_o   (rdata_o),
  .rresp_o   (rresp_o),
  .rready_i  (rready_i),
  .bus_o     (ps_bus)
);

sys_bus_interconnect interconnect_i (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .bus_i     (ps_bus),
  .hk_o      (hk_bus),
  .irq_o_bus (irq_bus)
);

rp_housekeeping housekeeping_i (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .bus_i    (hk_bus),
  .led_o    (led_o),
  .gpio_i   (gpio_i),
  .gpio_o   (gpio_o),
  .gpio_t_o (gpio_t_o)
);

rp_irq_ctrl irq_ctrl_i (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .bus_i   (irq_bus),
  .irq_i   (irq_i),
  .irq_o   (irq_o)
);

endmodule

`default_nettype wire

//--- src/rp_irq_ctrl.sv
// Interrupt controller
// Latches rising edges of the interrupt lines, masks them and
// drives one registered interrupt output, write one to clear
`timescale 1ns/1ps
`default_nettype none
`include "rp_bus_defines.svh"

module rp_irq_ctrl
  import rp_sys_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  sys_bus_if.s              bus_i,
  input  logic [`IRQ_W-1:0] irq_i,
  output logic              irq_o
);

irq_reg_e           ofs;
logic [`SYS_DW-1:0] rd_val;
logic [`SYS_DW-1:0] wr_val;
logic [`SYS_DW-1:0] wr_bits;   // Strobed write data only
logic               rd_ok;
logic [`IRQ_W-1:0]  irq_meta;
logic [`IRQ_W-1:0]  irq_sync;
logic [`IRQ_W-1:0]  irq_last;
logic [`IRQ_W-1:0]  rise;
logic [`IRQ_W-1:0]  clr;
logic [`IRQ_W-1:0]  pend_q;
logic [`IRQ_W-1:0]  mask_q;
logic               irq_q;
logic               ack_q;
logic               err_q;
logic [`SYS_DW-1:0] rdata_q;

assign ofs = irq_reg_e'(bus_i.addr[`REG_OW-1:0]);

always_comb begin
  rd_val = '0;
  rd_ok  = 1'b1;
  case (ofs)
    REG_PEND: rd_val[`IRQ_W-1:0] = pend_q;
    REG_MASK: rd_val[`IRQ_W-1:0] = mask_q;
    REG_RAW:  rd_val[`IRQ_W-1:0] = irq_sync;   // Read only
    default:  rd_ok = 1'b0;
  endcase
end

assign wr_val  = sys_merge(rd_val, bus_i.wdata, bus_i.sel);
assign wr_bits = sys_merge('0, bus_i.wdata, bus_i.sel);

assign rise = irq_sync & ~irq_last;
assign clr  = (bus_i.wen && ofs == REG_PEND) ? wr_bits[`IRQ_W-1:0] : '0;

//////////////////////////////
// Pending, mask and output
//////////////////////////////

always_ff @(posedge clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    irq_meta <= '0;
    irq_sync <= '0;
    irq_last <= '0;
    pend_q   <= '0;
    mask_q   <= '0;
    irq_q    <= 1'b0;
    ack_q    <= 1'b0;
    err_q    <= 1'b0;
  end else begin
    irq_meta <= irq_i;
    irq_sync <= irq_meta;
    irq_last <= irq_sync;
    pend_q   <= (pend_q & ~clr) | rise;   // New edge beats clear
    irq_q    <= |(pend_q & mask_q);
    if (bus_i.wen && ofs == REG_MASK) mask_q <= wr_val[`IRQ_W-1:0];
    ack_q <= bus_i.wen || bus_i.ren;
    // RAW and unknown offsets refuse writes
    err_q <= bus_i.wen ? !(ofs == REG_PEND || ofs == REG_MASK) : !rd_ok;
  end
end

always_ff @(posedge clk_i) begin
  if (bus_i.ren) rdata_q <= rd_val;
end

assign bus_i.ack   = ack_q;
assign bus_i.err   = err_q;
assign bus_i.rdata = rdata_q;
assign irq_o       = irq_q;

endmodule

`default_nettype wire

//--- src/rp_housekeeping.sv
// Housekeeping register block
// Board ID, LED, GPIO output and tristate registers, plus
// synchronized GPIO inputs
`timescale 1ns/1ps
`default_nettype none
`include "rp_bus_defines.svh"

module rp_housekeeping
  import rp_sys_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  sys_bus_if.s               bus_i,
  output logic [`LED_W-1:0]  led_o,
  input  logic [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o,
  output logic [`GPIO_W-1:0] gpio_t_o
);

hk_reg_e            ofs;
logic [`SYS_DW-1:0] rd_val;   // Current value at ofs
logic [`SYS_DW-1:0] wr_val;   // Same with strobed bytes replaced
logic               rd_ok;
logic               wr_ok;
logic [`LED_W-1:0]  led_q;
logic [`GPIO_W-1:0] gpio_o_q;
logic [`GPIO_W-1:0] gpio_t_q;
logic [`GPIO_W-1:0] gpio_meta;
logic [`GPIO_W-1:0] gpio_sync;
logic               ack_q;
logic               err_q;
logic [`SYS_DW-1:0] rdata_q;

assign ofs = hk_reg_e'(bus_i.addr[`REG_OW-1:0]);

// Register map, unused bits read zero
always_comb begin
  rd_val = '0;
  rd_ok  = 1'b1;
  wr_ok  = 1'b0;
  case (ofs)
    REG_ID:       rd_val = `HK_ID;                       // Read only
    REG_LED: begin
      rd_val[`LED_W-1:0] = led_q;
      wr_ok = 1'b1;
    end
    REG_GPIO_OUT: begin
      rd_val[`GPIO_W-1:0] = gpio_o_q;
      wr_ok = 1'b1;
    end
    REG_GPIO_TRI: begin
      rd_val[`GPIO_W-1:0] = gpio_t_q;
      wr_ok = 1'b1;
    end
    REG_GPIO_IN:  rd_val[`GPIO_W-1:0] = gpio_sync;       // Read only
    default:      rd_ok = 1'b0;
  endcase
end

assign wr_val = sys_merge(rd_val, bus_i.wdata, bus_i.sel);

//////////////////////////////
// Registers and ack
//////////////////////////////

always_ff @(posedge clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    ack_q    <= 1'b0;
    err_q    <= 1'b0;
    led_q    <= '0;
    gpio_o_q <= '0;
    gpio_t_q <= '1;   // All pins tristated
  end else begin
    ack_q <= bus_i.wen || bus_i.ren;
    err_q <= bus_i.wen ? !wr_ok : !rd_ok;
    if (bus_i.wen && wr_ok) begin
      case (ofs)
        REG_LED:      led_q    <= wr_val[`LED_W-1:0];
        REG_GPIO_OUT: gpio_o_q <= wr_val[`GPIO_W-1:0];
        REG_GPIO_TRI: gpio_t_q <= wr_val[`GPIO_W-1:0];
        default:      ;
      endcase
    end
  end
end

// Two flop input sync and read data
always_ff @(posedge clk_i) begin
  gpio_meta <= gpio_i;
  gpio_sync <= gpio_meta;
  if (bus_i.ren) rdata_q <= rd_val;
end

assign bus_i.ack   = ack_q;
assign bus_i.err   = err_q;
assign bus_i.rdata = rdata_q;

assign led_o    = led_q;
assign gpio_o   = gpio_o_q;
assign gpio_t_o = gpio_t_q;

endmodule

`default_nettype wire

//--- src/sys_bus_interconnect.sv
// System bus interconnect
// Decodes the slave select field, routes the pulse to one register
// block and muxes its answer back, unmapped slots get an error ack
`timescale 1ns/1ps
`default_nettype none
`include "rp_bus_defines.svh"

module sys_bus_interconnect
  import rp_sys_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  sys_bus_if.s bus_i,      // From the AXI slave
  sys_bus_if.m hk_o,       // Housekeeping
  sys_bus_if.m irq_o_bus   // Interrupt controller
);

sys_slave_e         slv;
logic [`SYS_AW-1:0] ofs;
logic               none_ack_q;  // Local ack for unmapped slots
logic               pend_q;      // Request outstanding

// Address held until ack, so decode stays put
always_comb begin
  case (bus_i.addr[`SLV_SEL_MSB:`SLV_SEL_LSB])
    'd0:     slv = SEL_HK;
    'd1:     slv = SEL_IRQ;
    default: slv = SEL_NONE;
  endcase
end

assign ofs = {{(`SYS_AW-`SLV_SEL_LSB){1'b0}}, bus_i.addr[`SLV_SEL_LSB-1:0]};

//////////////////////////////
// Request fan-out
//////////////////////////////

assign hk_o.addr       = ofs;
assign hk_o.wdata      = bus_i.wdata;
assign hk_o.sel        = bus_i.sel;
assign hk_o.wen        = bus_i.wen && (slv == SEL_HK);
assign hk_o.ren        = bus_i.ren && (slv == SEL_HK);

assign irq_o_bus.addr  = ofs;
assign irq_o_bus.wdata = bus_i.wdata;
assign irq_o_bus.sel   = bus_i.sel;
assign irq_o_bus.wen   = bus_i.wen && (slv == SEL_IRQ);
assign irq_o_bus.ren   = bus_i.ren && (slv == SEL_IRQ);

// Answer mux
always_comb begin
  case (slv)
    SEL_HK: begin
      bus_i.rdata = hk_o.rdata;
      bus_i.ack   = hk_o.ack;
      bus_i.err   = hk_o.err;
    end
    SEL_IRQ: begin
      bus_i.rdata = irq_o_bus.rdata;
      bus_i.ack   = irq_o_bus.ack;
      bus_i.err   = irq_o_bus.err;
    end
    default: begin
      bus_i.rdata = '0;
      bus_i.ack   = none_ack_q;
      bus_i.err   = none_ack_q;  // Always an error
    end
  endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    none_ack_q <= 1'b0;
    pend_q     <= 1'b0;
  end else begin
    none_ack_q <= (bus_i.wen || bus_i.ren) && (slv == SEL_NONE);
    pend_q     <= (pend_q && !bus_i.ack) || bus_i.wen || bus_i.ren;
  end
end

// Register blocks answer only what was asked
a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  bus_i.ack |-> pend_q);

endmodule

`default_nettype wire

//--- src/axi4_slave.sv
// Single-beat AXI4 slave
// Turns each AXI read or write into one system bus transfer,
// one at a time, response held until the host takes it
`timescale 1ns/1ps
`default_nettype none
`include "rp_bus_defines.svh"

module axi4_slave
  import rp_axi_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Write address and data
  input  logic [`SYS_AW-1:0] awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  logic [`SYS_DW-1:0] wdata_i,
  input  logic [`SYS_SW-1:0] wstrb_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  // Write response
  output logic               bvalid_o,
  output logic [1:0]         bresp_o,
  input  logic               bready_i,
  // Read address
  input  logic [`SYS_AW-1:0] araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  // Read data
  output logic               rvalid_o,
  output logic [`SYS_DW-1:0] rdata_o,
  output logic [1:0]         rresp_o,
  input  logic               rready_i,
  // System bus
  sys_bus_if.m               bus_o
);

axi_slv_state_e     state_q, state_d;
logic               is_wr_q;   // Transfer in flight is a write
axi_resp_e          resp_q;
logic [`SYS_AW-1:0] addr_q;
logic [`SYS_DW-1:0] wdata_q;
logic [`SYS_DW-1:0] rdata_q;
logic [`SYS_SW-1:0] sel_q;
logic               rd_hs;
logic               done;      // Ack seen while waiting

//////////////////////////////
// Address handshake
//////////////////////////////

assign awready_o = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
assign wready_o  = awready_o;  // AW and W taken together
assign arready_o = (state_q == ST_IDLE) && !awvalid_i && !wvalid_i;  // Write wins
assign rd_hs     = arready_o && arvalid_i;
assign done      = (state_q == ST_WAIT) && bus_o.ack;

//////////////////////////////
// FSM
//////////////////////////////

always_comb begin
  state_d = state_q;
  case (state_q)
    ST_IDLE: begin
      if (awready_o) state_d = ST_WR_REQ;
      else if (rd_hs) state_d = ST_RD_REQ;
    end
    ST_WR_REQ,
    ST_RD_REQ: state_d = ST_WAIT;  // Pulse lasts one cycle
    ST_WAIT:   if (done) state_d = is_wr_q ? ST_BRESP : ST_RRESP;
    ST_BRESP:  if (bready_i) state_d = ST_IDLE;
    ST_RRESP:  if (rready_i) state_d = ST_IDLE;
    default:   state_d = ST_IDLE;
  endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    state_q <= ST_IDLE;
    is_wr_q <= 1'b0;
    resp_q  <= OKAY;
  end else begin
    state_q <= state_d;
    if (awready_o) is_wr_q <= 1'b1;
    else if (rd_hs) is_wr_q <= 1'b0;
    if (done) resp_q <= bus_o.err ? SLVERR : OKAY;
  end
end

// Request payload, reads strobe all bytes
always_ff @(posedge clk_i) begin
  if (awready_o) begin
    addr_q  <= awaddr_i;
    wdata_q <= wdata_i;
    sel_q   <= wstrb_i;
  end else if (rd_hs) begin
    addr_q  <= araddr_i;
    wdata_q <= '0;
    sel_q   <= '1;
  end
  if (done && !is_wr_q) rdata_q <= bus_o.rdata;
end

//////////////////////////////
// Outputs
//////////////////////////////

assign bus_o.addr  = addr_q;
assign bus_o.wdata = wdata_q;
assign bus_o.sel   = sel_q;
assign bus_o.wen   = (state_q == ST_WR_REQ);
assign bus_o.ren   = (state_q == ST_RD_REQ);

assign bvalid_o = (state_q == ST_BRESP);
assign bresp_o  = resp_q;
assign rvalid_o = (state_q == ST_RRESP);
assign rresp_o  = resp_q;
assign rdata_o  = rdata_q;

// Never a read and a write on the system bus together
a_one_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  !(bus_o.wen && bus_o.ren));

a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  !(bvalid_o && rvalid_o));

// Back-pressure keeps the response steady
a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
  rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rdata_o));

endmodule

`default_nettype wire

//--- src/sys_bus_if.sv
// Simple system bus
// One wen or ren pulse per transfer, answered by a single ack
// with err and rdata valid in that cycle
`timescale 1ns/1ps
`default_nettype none
`include "rp_bus_defines.svh"

interface sys_bus_if;

  logic [`SYS_AW-1:0] addr;   // Held until ack
  logic [`SYS_DW-1:0] wdata;
  logic [`SYS_SW-1:0] sel;    // Byte strobes
  logic               wen;    // Write pulse
  logic               ren;    // Read pulse
  logic [`SYS_DW-1:0] rdata;
  logic               ack;
  logic               err;

  // Bus master side
  modport m (
    output addr, wdata, sel, wen, ren,
    input  rdata, ack, err
  );

  // Register block side
  modport s (
    input  addr, wdata, sel, wen, ren,
    output rdata, ack, err
  );

endinterface

`default_nettype wire

//--- src/rp_sys_pkg.sv
// System bus side types
// Slave select, register offsets and the byte strobe merge
`default_nettype none
`include "rp_bus_defines.svh"

package rp_sys_pkg;

  typedef enum logic [1:0] {
    SEL_HK   = 2'd0,
    SEL_IRQ  = 2'd1,
    SEL_NONE = 2'd2   // Unmapped slot, error ack
  } sys_slave_e;

  typedef enum logic [`REG_OW-1:0] {
    REG_ID       = `HK_OFS_ID,
    REG_LED      = `HK_OFS_LED,
    REG_GPIO_OUT = `HK_OFS_GPIO_OUT,
    REG_GPIO_TRI = `HK_OFS_GPIO_TRI,
    REG_GPIO_IN  = `HK_OFS_GPIO_IN
  } hk_reg_e;

  typedef enum logic [`REG_OW-1:0] {
    REG_PEND = `IRQ_OFS_PEND,
    REG_MASK = `IRQ_OFS_MASK,
    REG_RAW  = `IRQ_OFS_RAW
  } irq_reg_e;

  // Strobed bytes come from new_val, the rest keep old_val
  function automatic logic [`SYS_DW-1:0] sys_merge(
    input logic [`SYS_DW-1:0] old_val,
    input logic [`SYS_DW-1:0] new_val,
    input logic [`SYS_SW-1:0] sel
  );
    logic [`SYS_DW-1:0] res;
    res = old_val;
    for (int i = 0; i < `SYS_SW; i++) begin
      if (sel[i]) res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- src/rp_axi_pkg.sv
// AXI side types
// Response codes and the states of the single-beat slave
`default_nettype none

package rp_axi_pkg;

  // Only the two codes the bridge can return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [2:0] {
    ST_IDLE,     // Waiting for AW+W or AR
    ST_WR_REQ,   // wen pulse
    ST_RD_REQ,   // ren pulse
    ST_WAIT,     // Waiting for ack
    ST_BRESP,    // Write response held
    ST_RRESP     // Read data held
  } axi_slv_state_e;

endpackage

`default_nettype wire

//--- include/rp_bus_defines.svh
// System bus widths, register map and slave address window
// Shared by the AXI bridge, the interconnect and both register blocks
`ifndef RP_BUS_DEFINES_SVH
`define RP_BUS_DEFINES_SVH

// Bus widths
`define SYS_AW 32
`define SYS_DW 32
`define SYS_SW 4          // One strobe per byte

// Peripheral widths
`define LED_W  8
`define GPIO_W 16
`define IRQ_W  13

`define HK_ID 32'h5250_0001  // "RP" plus board revision

// Slave select field, bits above it are ignored
`define SLV_SEL_MSB 23
`define SLV_SEL_LSB 20
`define REG_OW      20    // Offset bits seen by a register block

// Housekeeping offsets
`define HK_OFS_ID       'h00
`define HK_OFS_LED      'h04
`define HK_OFS_GPIO_OUT 'h08
`define HK_OFS_GPIO_TRI 'h0C
`define HK_OFS_GPIO_IN  'h10

// Interrupt controller offsets
`define IRQ_OFS_PEND 'h00
`define IRQ_OFS_MASK 'h04
`define IRQ_OFS_RAW  'h08

`endif
